// ==== mips_dcache.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_lookup_if.sv
hw/dcache_tag_array.sv
hw/dcache_plru.sv
hw/dcache_data_array.sv
hw/mips_dcache.sv
bench/dcache_clock_gen.sv
bench/tb_mips_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mips_dcache.f --top-module tb_mips_dcache &&
    { sim_out="$(./obj_dir/Vtb_mips_dcache 2>&1)"; echo "$sim_out"; } &&
    grep -qx "ALL CHECKS PASSED" <<< "$sim_out" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// ==== bench/tb_mips_dcache.sv ====
/* Testbench for the 4-way data cache
   Table of accesses checked against a tag, valid and LRU model */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_defines.svh"

module tb_mips_dcache;

    typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE} op_t;

    typedef struct packed {
        logic [2:0]                test;        // Test number the row belongs to
        op_t                       op;
        logic [`DCACHE_WORD_W-1:0] addr;
        logic [`DCACHE_WORD_W-1:0] wdata;
        logic [`DCACHE_BYTES-1:0]  be;
        logic [`DCACHE_WORD_W-1:0] fill;        // Word the controller returns
        logic                      exp_stall;
        logic [`DCACHE_WORD_W-1:0] exp_rd;      // Read data after the access
    } row_t;

    logic                      clk, rst;
    logic                      read_en, write_en, data_valid, stall;
    logic [`DCACHE_WORD_W-1:0] addr, writedata, data_in, readdata;
    logic [`DCACHE_BYTES-1:0]  byte_en;

    // Reference model of the cache contents
    logic [`DCACHE_TAG_W-1:0]  m_tag   [`DCACHE_SETS][`DCACHE_WAYS];
    logic                      m_valid [`DCACHE_SETS][`DCACHE_WAYS];
    logic [2:0]                m_lru   [`DCACHE_SETS];   // Pair bit, then in-pair bits
    logic [`DCACHE_WORD_W-1:0] m_data  [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WORD_W-1:0] m_rd = '0;               // Read data register

    row_t rows[$];
    row_t cur;
    int   errors      = 0;
    int   test_errors = 0;
    int   tests_run   = 0;
    int   rst_cycles  = 0;
    bit   timed_out   = 1'b0;

    dcache_clock_gen clock_gen_inst (.clk(clk), .rst(rst));

    mips_dcache mips_dcache_inst (.*);

    function automatic string test_title(input logic [2:0] t);
        case (t)
            3'd1:    return "reset and first read";
            3'd2:    return "read miss fill";
            3'd3:    return "full write allocate";
            3'd4:    return "partial writes";
            default: return "pseudo-LRU replacement";
        endcase
    endfunction

    // Bytes of new_w where be is set, old_w elsewhere
    function automatic logic [31:0] merge_bytes(input logic [31:0] new_w,
                                                input logic [31:0] old_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    // Lowest empty way, else the way the tree bits lead to
    function automatic logic [1:0] pick_victim(input logic [2:0] set);
        logic [1:0] way;
        if (m_lru[set][2]) way = {1'b1, m_lru[set][1]};
        else way = {1'b0, m_lru[set][0]};
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[set][w[1:0]]) way = w[1:0];
        end
        return way;
    endfunction

    task automatic touch(input logic [2:0] set, input logic [1:0] way);
        m_lru[set][2] = (way < 2'd2);                     // Other pair is now older
        if (way < 2'd2) m_lru[set][0] = (way == 2'd0);  // Sibling is now older
        else m_lru[set][1] = (way == 2'd2);
    endtask

    // Expected stall and read data, model updated as the cache should be
    task automatic predict(inout row_t r);
        logic [2:0]               set;
        logic [`DCACHE_TAG_W-1:0] tag;
        logic [1:0]               way;
        bit                       hit;
        set         = r.addr[4:2];
        tag         = r.addr[31:5];
        hit         = 1'b0;
        way         = 2'd0;
        r.exp_stall = 1'b0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (m_valid[set][w[1:0]] && m_tag[set][w[1:0]] == tag) begin
                hit = 1'b1;
                way = w[1:0];
            end
        end
        if (r.op != OP_IDLE && !hit) begin
            way         = pick_victim(set);
            r.exp_stall = (r.op == OP_READ) || (r.be != 4'hF);
            if (r.exp_stall) m_rd = r.fill;   // Fetched word lands in the read register
            m_valid[set][way] = 1'b1;
            m_tag[set][way]   = tag;
            m_data[set][way]  = (r.op == OP_READ) ? r.fill : merge_bytes(r.wdata, r.fill, r.be);
            touch(set, way);
        end
        // The hit itself, or the held request once the fill is in
        if (r.op != OP_IDLE && (hit || r.exp_stall)) begin
            touch(set, way);
            if (r.op == OP_READ) m_rd = m_data[set][way];
            else m_data[set][way] = merge_bytes(r.wdata, m_data[set][way], r.be);
        end
        r.exp_rd = m_rd;
    endtask

    task automatic add_row(input logic [2:0] t, input op_t op, input logic [31:0] a,
                           input logic [3:0] be);
        row_t r;
        r       = '0;
        r.test  = t;
        r.op    = op;
        r.addr  = a;
        r.be    = be;
        r.wdata = $urandom;
        r.fill  = $urandom;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        int cycles;
        @(negedge clk);
        addr      = r.addr;
        writedata = r.wdata;
        byte_en   = r.be;
        read_en   = (r.op == OP_READ);
        write_en  = (r.op == OP_WRITE);
        #1;
        assert (stall === r.exp_stall) else begin
            $display("FAILED at %0t: stall %b, expected %b for %h", $time, stall, r.exp_stall,
                     r.addr);
            test_errors++;
        end
        if (stall) begin
            repeat (1 + $urandom % 3) @(negedge clk);   // Controller latency
            data_valid = 1'b1;
            data_in    = r.fill;
            #1;
            assert (readdata === r.fill) else begin
                $display("FAILED at %0t: readdata %h during fill, expected %h", $time,
                         readdata, r.fill);
                test_errors++;
            end
            cycles = 0;
            do begin                                  // Held request hits after the fill edge
                @(negedge clk);
                data_valid = 1'b0;
                data_in    = '0;
                #1;
                cycles++;
            end while (stall && cycles < 4);
            if (stall) begin
                $display("Timeout: stall still high 4 cycles after the fill of %h", r.addr);
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        read_en  = 1'b0;
        write_en = 1'b0;
        #1;
        assert (readdata === r.exp_rd) else begin
            $display("FAILED at %0t: readdata %h, expected %h after access to %h", $time,
                     readdata, r.exp_rd, r.addr);
            test_errors++;
        end
    endtask

    task automatic report_test(input logic [2:0] t);
        tests_run++;
        if (test_errors == 0) $display("Test %0d %s: pass", t, test_title(t));
        else $display("Test %0d %s: %0d mismatches", t, test_title(t), test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        read_en    = 1'b0;
        write_en   = 1'b0;
        data_valid = 1'b0;
        addr       = '0;
        writedata  = '0;
        data_in    = '0;
        byte_en    = '0;
        void'($urandom(50));
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            m_lru[s[2:0]] = 3'b000;
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                m_valid[s[2:0]][w[1:0]] = 1'b0;
            end
        end
        add_row(1, OP_IDLE, 32'h0000_0000, 4'h0);
        add_row(1, OP_IDLE, 32'h0000_0000, 4'h0);
        add_row(1, OP_READ, 32'h0000_0040, 4'hF);    // Set 0, cold miss
        add_row(2, OP_READ, 32'h0000_0104, 4'hF);    // Set 1, miss then held hit
        add_row(2, OP_READ, 32'h0000_0104, 4'hF);
        add_row(3, OP_WRITE, 32'h0000_0208, 4'hF);   // Allocates without stall
        add_row(3, OP_READ, 32'h0000_0208, 4'hF);
        add_row(4, OP_WRITE, 32'h0000_0104, 4'b0101);
        add_row(4, OP_READ, 32'h0000_0104, 4'hF);
        add_row(4, OP_WRITE, 32'h0000_030C, 4'b0011); // Partial miss needs a fetch
        add_row(4, OP_READ, 32'h0000_030C, 4'hF);
        add_row(5, OP_READ, 32'h1000_0018, 4'hF);    // Set 6 filled in way order
        add_row(5, OP_READ, 32'h2000_0018, 4'hF);
        add_row(5, OP_READ, 32'h3000_0018, 4'hF);
        add_row(5, OP_READ, 32'h4000_0018, 4'hF);
        add_row(5, OP_READ, 32'h1000_0018, 4'hF);    // Ways 0 and 2 made recent
        add_row(5, OP_READ, 32'h3000_0018, 4'hF);
        add_row(5, OP_READ, 32'h5000_0018, 4'hF);    // Evicts way 1
        add_row(5, OP_READ, 32'h1000_0018, 4'hF);
        add_row(5, OP_READ, 32'h3000_0018, 4'hF);
        add_row(5, OP_READ, 32'h4000_0018, 4'hF);
        add_row(5, OP_READ, 32'h2000_0018, 4'hF);    // Evicted tag misses again
        foreach (rows[i]) begin
            cur = rows[i];
            predict(cur);
            rows[i] = cur;
        end
        while (rst !== 1'b0 && rst_cycles < 16) begin   // Also covers rst still unknown
            @(negedge clk);
            rst_cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
        foreach (rows[i]) begin
            if (!timed_out) begin
                apply_row(rows[i]);
                if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test)
                    report_test(rows[i].test);
            end
        end
        $display("Tests run: %0d, mismatches: %0d, timeout: %0d", tests_run, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/dcache_clock_gen.sv ====
/* Testbench clock and reset
   40 ns clock, reset held for the first 8 cycles */
`timescale 1ns/100ps
`default_nettype none

module dcache_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);           // Release between rising edges
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/mips_dcache.sv ====
/* 4-way set-associative data cache for a MIPS-style CPU
   Tag match, pseudo-LRU and data storage joined by one lookup bus */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_defines.svh"

module mips_dcache import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      read_en,
    input  logic                      write_en,
    input  logic                      data_valid,
    input  logic [`DCACHE_WORD_W-1:0] addr,
    input  logic [`DCACHE_WORD_W-1:0] writedata,
    input  logic [`DCACHE_WORD_W-1:0] data_in,
    input  logic [`DCACHE_BYTES-1:0]  byte_en,
    output logic [`DCACHE_WORD_W-1:0] readdata,
    output logic                      stall       // Also seen by the controller
);

    dcache_addr_u addr_u;
    dcache_lookup_if lk ();

    assign addr_u.raw = addr;

    dcache_tag_array tag_array_inst (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr_u),
        .read_en    (read_en),
        .write_en   (write_en),
        .byte_en    (byte_en),
        .data_valid (data_valid),
        .stall      (stall),
        .lk         (lk.tags)
    );

    dcache_plru plru_inst (.clk(clk), .rst(rst), .lk(lk.lru));

    dcache_data_array data_array_inst (
        .clk        (clk),
        .read_en    (read_en),
        .write_en   (write_en),
        .writedata  (writedata),
        .byte_en    (byte_en),
        .data_in    (data_in),
        .data_valid (data_valid),
        .readdata   (readdata),
        .lk         (lk.data)
    );

endmodule

`default_nettype wire

// ==== hw/dcache_data_array.sv ====
/* Data word storage with byte-enable merge
   Registered read data with controller bypass */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_defines.svh"

module dcache_data_array import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      read_en,
    input  logic                      write_en,
    input  logic [`DCACHE_WORD_W-1:0] writedata,
    input  logic [`DCACHE_BYTES-1:0]  byte_en,
    input  logic [`DCACHE_WORD_W-1:0] data_in,
    input  logic                      data_valid,
    output logic [`DCACHE_WORD_W-1:0] readdata,
    dcache_lookup_if.data             lk
);

    logic [`DCACHE_WORD_W-1:0] data_mem [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WORD_W-1:0] hit_word;      // Word at the hit way
    logic [`DCACHE_WORD_W-1:0] hit_merged;
    logic [`DCACHE_WORD_W-1:0] fill_word;
    logic [`DCACHE_WORD_W-1:0] readdata_reg = '0;

    // Enabled bytes from new_word, the rest kept from old_word
    function automatic logic [`DCACHE_WORD_W-1:0] byte_merge(
        input logic [`DCACHE_WORD_W-1:0] new_word,
        input logic [`DCACHE_WORD_W-1:0] old_word,
        input logic [`DCACHE_BYTES-1:0]  be
    );
        logic [`DCACHE_WORD_W-1:0] result;
        result = old_word;
        for (int b = 0; b < `DCACHE_BYTES; b++) begin
            if (be[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    assign hit_word   = data_mem[lk.set_idx][lk.hit_idx];
    assign hit_merged = byte_merge(writedata, hit_word, byte_en);

    // Read fill takes the fetched word, write fill overlays writedata
    assign fill_word = read_en ? data_in : byte_merge(writedata, data_in, byte_en);

    always_ff @(posedge clk) begin
        if (lk.fill) begin
            data_mem[lk.set_idx][lk.fill_way] <= fill_word;
        end else if (lk.tag_hit && write_en) begin
            data_mem[lk.set_idx][lk.hit_idx] <= hit_merged;
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill && data_valid) begin
            readdata_reg <= data_in;      // Fetched word seen by the CPU
        end else if (lk.tag_hit && read_en) begin
            readdata_reg <= hit_word;
        end
    end

    assign readdata = data_valid ? data_in : readdata_reg;   // Bypass while filling

    // Fill only ever follows a miss decided in the tag array
    a_fill_not_hit: assert property (@(posedge clk) !(lk.fill && lk.tag_hit));

endmodule

`default_nettype wire

// ==== hw/dcache_plru.sv ====
/* Tree pseudo-LRU, 3 bits per set
   Picks the lowest invalid way, else follows the tree */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_defines.svh"

module dcache_plru import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    dcache_lookup_if.lru lk
);

    // Bit 2 selects the LRU pair, bit 1 way 2/3, bit 0 way 0/1
    logic [2:0] lru_mem [`DCACHE_SETS];
    logic [2:0] lru_bits;
    logic [2:0] lru_next;
    way_idx_t   lru_way;     // Where the tree points
    way_idx_t   victim;
    way_idx_t   touch_way;
    logic       touch;

    assign lru_bits = lru_mem[lk.set_idx];

    always_comb begin
        casez (lru_bits)
            3'b0?0:  lru_way = 2'd0;
            3'b0?1:  lru_way = 2'd1;
            3'b10?:  lru_way = 2'd2;
            default: lru_way = 2'd3;
        endcase
    end

    // Empty ways first, lowest number wins
    always_comb begin
        victim = lru_way;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!lk.valid_vec[w]) victim = way_idx_t'(w);
        end
    end
    assign lk.fill_way = victim;   // Independent of fill, no loop

    assign touch     = lk.fill | lk.tag_hit;
    assign touch_way = lk.fill ? lk.fill_way : lk.hit_idx;

    // Point away from the touched way at both tree levels
    always_comb begin
        lru_next    = lru_bits;
        lru_next[2] = ~touch_way[1];
        if (touch_way[1]) begin
            lru_next[1] = ~touch_way[0];
        end else begin
            lru_next[0] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                lru_mem[s] <= '0;
            end
        end else if (touch) begin
            lru_mem[lk.set_idx] <= lru_next;
        end
    end

    // Full set evicts exactly the tree's choice
    a_full_victim: assert property (@(posedge clk) disable iff (rst)
        lk.fill && (&lk.valid_vec) |->
            lk.fill_way == {lru_bits[2], lru_bits[2] ? lru_bits[1] : lru_bits[0]});

    // Encoded hit agrees with the one-hot match
    a_hit_idx: assert property (@(posedge clk) disable iff (rst)
        lk.tag_hit |-> lk.hit_way[lk.hit_idx]);

endmodule

`default_nettype wire

// ==== hw/dcache_tag_array.sv ====
/* Tag and valid storage with parallel match
   Makes the miss, stall and fill decision for the whole cache */
`timescale 1ns/100ps
`default_nettype none
`include "dcache_defines.svh"

module dcache_tag_array import dcache_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_addr_u             addr,
    input  logic                     read_en,
    input  logic                     write_en,
    input  logic [`DCACHE_BYTES-1:0] byte_en,
    input  logic                     data_valid,
    output logic                     stall,
    dcache_lookup_if.tags            lk
);

    logic [`DCACHE_TAG_W-1:0] tag_mem [`DCACHE_SETS][`DCACHE_WAYS];
    way_vec_t                 valid_mem [`DCACHE_SETS];
    way_vec_t                 match;        // Raw compare, any cycle
    logic                     access;
    logic                     full_write;   // Whole word overwritten, no fetch needed

    assign access     = read_en | write_en;
    assign full_write = write_en & (&byte_en);

    assign lk.set_idx   = addr.fields.set;
    assign lk.valid_vec = valid_mem[lk.set_idx];

    // All four ways compared at once
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            match[w] = lk.valid_vec[w] && (tag_mem[lk.set_idx][w] == addr.fields.tag);
        end
    end
    assign lk.hit_way = match;

    always_comb begin
        case (match)
            4'b0010: lk.hit_idx = 2'd1;
            4'b0100: lk.hit_idx = 2'd2;
            4'b1000: lk.hit_idx = 2'd3;
            default: lk.hit_idx = 2'd0;   // Way 0 or no match
        endcase
    end

    assign lk.tag_hit = access & (|match);

    // Miss waits for the controller unless the whole word is written
    assign stall   = ~lk.tag_hit & (read_en | (write_en & ~(&byte_en)));
    assign lk.fill = access & ~(|match) & (data_valid | full_write);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (lk.fill) begin
            valid_mem[lk.set_idx][lk.fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill) tag_mem[lk.set_idx][lk.fill_way] <= addr.fields.tag;
    end

    // A tag can live in one way of a set only
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(lk.hit_way));

    // A held request hits right after its fill
    a_fill_then_hit: assert property (@(posedge clk) disable iff (rst)
        $past(lk.fill) && access && $stable(addr) |-> lk.tag_hit);

endmodule

`default_nettype wire

// ==== hw/dcache_lookup_if.sv ====
/* Lookup and fill results shared by the cache blocks */
`timescale 1ns/100ps
`default_nettype none

interface dcache_lookup_if import dcache_pkg::*; ();

    set_idx_t set_idx;      // Addressed set
    logic     tag_hit;      // Access that hits
    way_vec_t hit_way;      // One-hot tag match
    way_idx_t hit_idx;      // Encoded match
    way_vec_t valid_vec;    // Valid bits of the addressed set
    logic     fill;         // Write a new line this edge
    way_idx_t fill_way;     // Victim picked by the LRU block

    // Tag side makes every decision
    modport tags (
        output set_idx, tag_hit, hit_way, hit_idx, valid_vec, fill,
        input  fill_way
    );

    // Replacement state, names the victim
    modport lru (
        input  set_idx, tag_hit, hit_way, hit_idx, valid_vec, fill,
        output fill_way
    );

    modport data (
        input set_idx, tag_hit, hit_idx, fill, fill_way
    );

endinterface

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
/* Data cache types
   Address views and way/set numbering */
`default_nettype none
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WAY_W-1:0] way_idx_t;   // Way number
    typedef logic [`DCACHE_WAYS-1:0]  way_vec_t;   // One bit per way
    typedef logic [`DCACHE_SET_W-1:0] set_idx_t;   // Set number

    // CPU byte address split into cache fields
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0] tag;
        set_idx_t                 set;
        logic [`DCACHE_OFF_W-1:0] offset;   // Byte lane, words are aligned
    } dcache_addr_fields_t;

    typedef union packed {
        logic [`DCACHE_WORD_W-1:0] raw;     // As the CPU drives it
        dcache_addr_fields_t       fields;
    } dcache_addr_u;

endpackage

`default_nettype wire

// ==== hw/dcache_defines.svh ====
/* Data cache geometry
   4-way, 8-set cache of single 32-bit words */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Word and address width
`define DCACHE_WORD_W 32
`define DCACHE_BYTES 4     // Bytes per word

// Organisation
`define DCACHE_WAYS 4
`define DCACHE_WAY_W 2     // Way number width
`define DCACHE_SETS 8
`define DCACHE_SET_W 3     // Set index width

// Address split, top to bottom
`define DCACHE_TAG_W 27
`define DCACHE_OFF_W 2     // Byte offset inside a word

`endif
